//--- src.f
+incdir+rtl
rtl/wconv_pkg.sv
rtl/line_bank_ram.sv
rtl/word_source_mem.sv
rtl/width_conv_32_to_512.sv
rtl/wconv_top.sv
tb/tb_wconv.sv

//--- tb/tb_wconv.sv
`timescale 1ns/1ps
`include "wconv_config.svh"

module tb_wconv
   import wconv_pkg::*;
();

   localparam int CLK_HALF       = 20;
   localparam int TIMEOUT_CYCLES = 4000;   // three loads and three transfers need about 3800
   localparam int LINES          = `WCONV_LINES;
   localparam int WPL            = `WCONV_WORDS_PER_LINE;

   logic         clk;
   logic         reset;
   logic         start;
   logic         load_we;
   word_idx_t    load_addr;
   word_t        load_data;
   stream_beat_t beat;

   word_t  ref_mem [`WCONV_SRC_WORDS];   // what the source memory should hold
   integer seed;
   int     cycle_cnt = 0;
   int     beat_idx;                     // position of the next beat inside its packet
   int     packets_requested;
   int     packets_started;
   int     packets_done;

   wconv_top u_wconv_top (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .load_we   (load_we),
      .load_addr (load_addr),
      .load_data (load_data),
      .beat      (beat)
   );

   always #(CLK_HALF) clk = ~clk;

   task automatic report_mismatch(input string msg);
      $display("Mismatch at time %0t: %s", $time, msg);
      $display("SIMULATION FAILED");
      $fatal(1, "value check failed");
   endtask

   task automatic report_failure(input string msg);
      $display("Error at time %0t: %s", $time, msg);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped");
   endtask

   // the first word of a line sits in the top bits
   function automatic line_t expected_line(input int k);
      line_t l;
      int    j;
      l = '0;
      for (j = 0; j < WPL; j++) begin
         l[`WCONV_LINE_W-1-`WCONV_WORD_W*j -: `WCONV_WORD_W] = ref_mem[WPL*k + j];
      end
      return l;
   endfunction

   // fills the whole source memory, one word per cycle
   task automatic load_random();
      for (int i = 0; i < `WCONV_SRC_WORDS; i++) begin
         @(negedge clk);
         load_we    = 1'b1;
         load_addr  = word_idx_t'(i);
         load_data  = $random(seed);
         ref_mem[i] = load_data;
      end
      @(negedge clk);
      load_we = 1'b0;
   endtask

   task automatic pulse_start();
      @(negedge clk);
      start = 1'b1;
      packets_requested++;
      @(negedge clk);
      start = 1'b0;
   endtask

   // returns once the monitor has counted target packets
   task automatic wait_packets(input int target);
      while (packets_done < target) begin
         @(negedge clk);
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic check_idle_beat(input string when_msg);
      assert (beat === '0)
         else report_mismatch($sformatf("beat not cleared %s", when_msg));
   endtask

   // monitor, compares every beat against the reference memory
   always @(posedge clk) begin
      if (!reset) begin
         if (beat.valid) begin
            if (beat_idx == 0) begin
               packets_started++;
               assert (packets_started <= packets_requested)
                  else report_failure("a packet started without a rising edge on start");
            end
            assert (beat.sop === (beat_idx == 0))
               else report_mismatch($sformatf("sop is %b on beat %0d", beat.sop, beat_idx));
            assert (beat.eop === (beat_idx == LINES - 1))
               else report_mismatch($sformatf("eop is %b on beat %0d", beat.eop, beat_idx));
            assert (beat.data === expected_line(beat_idx))
               else report_mismatch($sformatf("data of beat %0d is %h, expected %h",
                                              beat_idx, beat.data, expected_line(beat_idx)));
            if (beat_idx == LINES - 1) begin
               beat_idx = 0;
               packets_done++;
            end else begin
               beat_idx++;
            end
         end else begin
            assert (beat_idx == 0)
               else report_failure($sformatf("valid dropped after %0d beats", beat_idx));
         end
      end
   end

   sop_with_valid: assert property (@(posedge clk) disable iff (reset) beat.sop |-> beat.valid)
      else report_mismatch("sop high without valid");

   eop_with_valid: assert property (@(posedge clk) disable iff (reset) beat.eop |-> beat.valid)
      else report_mismatch("eop high without valid");

   eop_ends_packet: assert property (@(posedge clk) disable iff (reset) beat.eop |=> !beat.valid)
      else report_failure("valid stayed high after the last beat");

   reset_clears_beat: assert property (@(posedge clk) reset |=> (beat == '0))
      else report_mismatch("beat not cleared by reset");

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
         $display("SIMULATION FAILED");
         $fatal(1, "timeout");
      end
   end

   initial begin
      seed              = 2;
      clk               = 1'b0;
      reset             = 1'b1;
      start             = 1'b0;
      load_we           = 1'b0;
      load_addr         = '0;
      load_data         = '0;
      beat_idx          = 0;
      packets_requested = 0;
      packets_started   = 0;
      packets_done      = 0;

      repeat (4) begin
         @(negedge clk);
         check_idle_beat("during reset");
      end
      reset = 1'b0;
      @(negedge clk);
      check_idle_beat("after reset");
      idle_cycles(2);

      // one plain transfer covers content and framing
      load_random();
      pulse_start();
      wait_packets(1);
      idle_cycles(8);

      // start stays high, with a second edge in the middle of the output phase
      load_random();
      @(negedge clk);
      start = 1'b1;
      packets_requested++;
      while (!(packets_started == 2 && beat_idx >= LINES / 2)) begin
         @(negedge clk);
      end
      start = 1'b0;
      @(negedge clk);
      start = 1'b1;                        // edge lands while the packet plays out
      wait_packets(2);
      // still high for longer than a whole transfer, so nothing may follow
      idle_cycles(`WCONV_SRC_WORDS + LINES);
      assert (packets_started == 2)
         else report_failure("a held start level began another transfer");
      start = 1'b0;

      // new data must replace the old lines in the buffer
      load_random();
      pulse_start();
      wait_packets(3);
      idle_cycles(8);

      if (packets_done == 3 && packets_started == 3 && beat_idx == 0) begin
         $display("SIMULATION PASSED");
         $finish;
      end else begin
         report_failure($sformatf("%0d packets started and %0d completed, 3 expected",
                                  packets_started, packets_done));
      end
   end

endmodule

//--- rtl/wconv_top.sv
`timescale 1ns/1ps

module wconv_top
   import wconv_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         start,

   // source memory fill, only between transfers
   input  logic         load_we,
   input  word_idx_t    load_addr,
   input  word_t        load_data,

   output stream_beat_t beat
);

   // converter read side of the source memory
   byte_addr_t data_addr;
   logic       data_oe;
   word_t      data_q;

   word_source_mem u_src (
      .clk       (clk),
      .reset     (reset),
      .load_we   (load_we),
      .load_addr (load_addr),
      .load_data (load_data),
      .data_addr (data_addr),
      .data_oe   (data_oe),
      .data_q    (data_q)
   );

   // reads one burst, packs it into lines and plays the packet out
   width_conv_32_to_512 u_conv (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .data_addr (data_addr),
      .data_oe   (data_oe),
      .data_q    (data_q),
      .beat      (beat)
   );

endmodule

//--- rtl/width_conv_32_to_512.sv
`timescale 1ns/1ps
`include "wconv_config.svh"

module width_conv_32_to_512
   import wconv_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         start,

   // source memory read port
   output byte_addr_t   data_addr,
   output logic         data_oe,
   input  word_t        data_q,

   output stream_beat_t beat
);

   localparam int PACK_W = `WCONV_LINE_W - `WCONV_WORD_W;       // words 0..14 of a line
   localparam int SUB_W  = $clog2(`WCONV_WORDS_PER_LINE);       // word position in a line
   localparam word_idx_t LAST_WORD = word_idx_t'(`WCONV_SRC_WORDS - 1);
   localparam line_idx_t LAST_BEAT = line_idx_t'(`WCONV_LINES - 1);

   conv_state_t state;
   logic        start_d;
   logic        start_edge;
   word_idx_t   word_cnt;
   line_idx_t   beat_cnt;
   logic        line_done;

   logic [PACK_W-1:0] pack;

   logic      bank_we;
   line_idx_t bank_waddr;
   line_idx_t bank_raddr;
   line_t     bank_din;
   line_t     bank_dout;

   assign start_edge = start & ~start_d;
   assign line_done  = (state == FILL) &&
                       (word_cnt[SUB_W-1:0] == SUB_W'(`WCONV_WORDS_PER_LINE - 1));

   // one bank per 32-bit slice, bank i holds bits [32i+31:32i] of every line
   for (genvar i = 0; i < `WCONV_WORDS_PER_LINE; i++) begin : g_bank
      line_bank_ram #(
         .WIDTH (`WCONV_WORD_W),
         .DEPTH (`WCONV_LINE_AW)
      ) u_bank (
         .clk      (clk),
         .reset    (reset),
         .waddress (bank_waddr),
         .din      (bank_din[i*`WCONV_WORD_W +: `WCONV_WORD_W]),
         .we       (bank_we),
         .raddress (bank_raddr),
         .dout     (bank_dout[i*`WCONV_WORD_W +: `WCONV_WORD_W])
      );
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= IDLE;
         start_d    <= 1'b0;
         data_addr  <= '0;
         data_oe    <= 1'b0;
         word_cnt   <= '0;
         beat_cnt   <= '0;
         bank_we    <= 1'b0;
         bank_raddr <= '0;
         beat       <= '0;
      end else begin
         start_d <= start;
         bank_we <= 1'b0;

         case (state)
            IDLE: begin
               word_cnt   <= '0;
               beat_cnt   <= '0;
               bank_raddr <= '0;
               beat.valid <= 1'b0;
               beat.sop   <= 1'b0;
               beat.eop   <= 1'b0;
               if (start_edge) begin
                  state     <= PRIME;
                  data_addr <= '0;
                  data_oe   <= 1'b1;
               end
            end

            // word 0 is being read, it shows on data_q in the first FILL cycle
            PRIME: begin
               state     <= FILL;
               data_addr <= data_addr + 32'd4;
            end

            FILL: begin
               data_addr <= data_addr + 32'd4;
               word_cnt  <= word_cnt + 1'b1;
               if (word_cnt == LAST_WORD - 1'b1) begin
                  data_oe <= 1'b0;                  // the last word was requested last cycle
               end
               if (line_done) begin
                  bank_we <= 1'b1;
               end
               if (word_cnt == LAST_WORD) begin
                  state      <= PLAY;
                  bank_raddr <= line_idx_t'(1);     // line 0 is already on dout
               end
            end

            PLAY: begin
               bank_raddr <= bank_raddr + 1'b1;
               beat_cnt   <= beat_cnt + 1'b1;
               beat.valid <= 1'b1;
               beat.sop   <= (beat_cnt == '0);
               beat.eop   <= (beat_cnt == LAST_BEAT);
               beat.data  <= bank_dout;
               if (beat_cnt == LAST_BEAT) begin
                  state <= IDLE;
               end
            end

            default: state <= IDLE;
         endcase
      end
   end

   // packing path, the first word of a line ends up in the top bits
   always_ff @(posedge clk) begin
      if (state == FILL) begin
         pack <= {pack[PACK_W-`WCONV_WORD_W-1:0], data_q};
         if (line_done) begin
            bank_din   <= {pack, data_q};
            bank_waddr <= word_cnt[`WCONV_SRC_AW-1:SUB_W];   // line number k
         end
      end
   end

endmodule

//--- rtl/word_source_mem.sv
`timescale 1ns/1ps
`include "wconv_config.svh"

module word_source_mem
   import wconv_pkg::*;
(
   input  logic       clk,
   input  logic       reset,

   // load port, used while no transfer is running
   input  logic       load_we,
   input  word_idx_t  load_addr,
   input  word_t      load_data,

   // read port driven by the converter
   input  byte_addr_t data_addr,
   input  logic       data_oe,
   output word_t      data_q
);

   word_t     mem [`WCONV_SRC_WORDS];
   word_idx_t rd_idx;

   // the two low bits select a byte inside the word and are dropped
   assign rd_idx = data_addr[`WCONV_SRC_AW+1:2];   // bits above the array size wrap

   always_ff @(posedge clk) begin
      if (load_we) begin
         mem[load_addr] <= load_data;
      end
   end

   // data_q holds its last word while data_oe is low
   always_ff @(posedge clk) begin
      if (reset) begin
         data_q <= '0;
      end else if (data_oe) begin
         data_q <= mem[rd_idx];
      end
   end

endmodule

//--- rtl/line_bank_ram.sv
`timescale 1ns/1ps

module line_bank_ram #(
   parameter int WIDTH = 32,
   parameter int DEPTH = 5          // address width, the bank holds 2**DEPTH entries
) (
   input  logic             clk,
   input  logic             reset,
   input  logic [DEPTH-1:0] waddress,
   input  logic [WIDTH-1:0] din,
   input  logic             we,
   input  logic [DEPTH-1:0] raddress,
   output logic [WIDTH-1:0] dout
);

   logic [WIDTH-1:0] mem [2**DEPTH];

   // write port
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddress] <= din;
      end
   end

   // a read of the address being written returns the old entry
   always_ff @(posedge clk) begin
      if (reset) begin
         dout <= '0;
      end else begin
         dout <= mem[raddress];
      end
   end

endmodule

//--- rtl/wconv_pkg.sv
`include "wconv_config.svh"

package wconv_pkg;

   typedef logic [`WCONV_WORD_W-1:0] word_t;
   typedef logic [`WCONV_LINE_W-1:0] line_t;

   typedef logic [31:0] byte_addr_t;              // source byte address, steps by 4
   typedef logic [`WCONV_SRC_AW-1:0] word_idx_t;
   typedef logic [`WCONV_LINE_AW-1:0] line_idx_t;

   // one beat of the output packet
   typedef struct packed {
      logic  valid;
      logic  sop;
      logic  eop;
      line_t data;
   } stream_beat_t;

   // converter phases, PRIME covers the first memory read latency
   typedef enum logic [1:0] {
      IDLE,
      PRIME,
      FILL,
      PLAY
   } conv_state_t;

endpackage

//--- rtl/wconv_config.svh
`ifndef WCONV_CONFIG_SVH
`define WCONV_CONFIG_SVH

// width of one source word in bits
`define WCONV_WORD_W 32

// width of one packed output line in bits
`define WCONV_LINE_W 512

// number of source words that make up one line
`define WCONV_WORDS_PER_LINE 16

`define WCONV_LINES 32             // lines per burst, also the line buffer depth
`define WCONV_LINE_AW 5            // line buffer address width

// one burst covers the whole source memory, 2048 bytes
`define WCONV_SRC_WORDS 512
`define WCONV_SRC_AW 9             // source word index width

`endif
